// File: src/tile_window_pkg.sv
package tile_window_pkg;

        // Pixel format.
        localparam int PIXEL_W = 8;
        typedef logic [PIXEL_W-1:0] pixel_t;

        // Tile geometry.
        localparam int TILE_W      = 4;
        localparam int TILE_PIXELS = TILE_W * TILE_W;
        localparam int TILE_COUNT  = 4;

        // A window needs its lower-right neighbour, which lies TILE_W + 1 pixels
        // ahead of the centre, so the read phase trails the write phase by one more.
        localparam int WINDOW_LAG = TILE_W + 2;
        localparam int SLOT_LEN   = TILE_PIXELS + WINDOW_LAG;
        localparam int FRAME_LEN  = SLOT_LEN * TILE_COUNT;

        // Derived widths.
        localparam int ADDR_W     = $clog2(TILE_PIXELS);
        localparam int TILE_IDX_W = $clog2(TILE_COUNT);
        localparam int CNT_W      = $clog2(FRAME_LEN + 1);

        // Sequencer states.
        typedef enum logic [1:0] {
                SEQ_IDLE,
                SEQ_RUN,
                SEQ_DONE
        } seq_state_t;

endpackage

// File: src/tile_sequencer.sv
`timescale 1ns/1ps

module tile_sequencer import tile_window_pkg::*;
(
        input  logic                  clk,
        input  logic                  rst_n,
        input  logic                  rd,
        output logic [TILE_COUNT-1:0] wr_sel,
        output logic [ADDR_W-1:0]     wr_addr,
        output logic [TILE_COUNT-1:0] rd_sel,
        output logic [ADDR_W-1:0]     rd_centre,
        output logic [TILE_IDX_W-1:0] rd_tile,
        output logic                  rd_req,
        output logic                  done
);

        seq_state_t            state;
        logic [CNT_W-1:0]      cnt;
        logic                  active;
        logic [TILE_IDX_W-1:0] slot;
        logic [CNT_W-1:0]      phase;
        logic [TILE_COUNT-1:0] slot_hot;

        // A cycle counts only while rd is high and the frame is not finished.
        assign active = rd && (state != SEQ_DONE);
        assign done   = (state == SEQ_DONE);

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        state <= SEQ_IDLE;
                        cnt   <= '0;
                end
                else if (active)
                begin
                        cnt <= cnt + 1'b1;
                        if (cnt == CNT_W'(FRAME_LEN - 1))
                        begin
                                state <= SEQ_DONE;
                        end
                        else
                        begin
                                state <= SEQ_RUN;
                        end
                end
        end

        // Split the frame counter into slot and phase by comparing against
        // the slot boundaries.
        always_comb
        begin
                slot  = '0;
                phase = cnt;
                for (int k = 1; k < TILE_COUNT; k++)
                begin
                        if (cnt >= CNT_W'(k * SLOT_LEN))
                        begin
                                slot  = TILE_IDX_W'(k);
                                phase = cnt - CNT_W'(k * SLOT_LEN);
                        end
                end
        end

        assign slot_hot = {{(TILE_COUNT-1){1'b0}}, 1'b1} << slot;

        // Write phase covers the first TILE_PIXELS cycles of the slot.
        assign wr_sel  = (active && (phase < CNT_W'(TILE_PIXELS))) ? slot_hot : '0;
        assign wr_addr = ADDR_W'(phase);

        // Window requests start WINDOW_LAG cycles into the slot.
        assign rd_req    = active && (phase >= CNT_W'(WINDOW_LAG));
        assign rd_sel    = rd_req ? slot_hot : '0;
        assign rd_centre = ADDR_W'(phase - CNT_W'(WINDOW_LAG));
        assign rd_tile   = slot;

endmodule

// File: src/tile_store.sv
`timescale 1ns/1ps

module tile_store import tile_window_pkg::*;
(
        input  logic              clk,
        input  logic              rst_n,
        input  logic              wr_en,
        input  logic [ADDR_W-1:0] wr_addr,
        input  pixel_t            wr_data,
        input  logic              rd_en,
        input  logic [ADDR_W-1:0] rd_centre,
        output pixel_t            win0,
        output pixel_t            win1,
        output pixel_t            win2,
        output pixel_t            win3,
        output pixel_t            win4,
        output pixel_t            win5,
        output pixel_t            win6,
        output pixel_t            win7,
        output pixel_t            win8
);

        pixel_t mem [TILE_PIXELS];
        pixel_t nbr [9];
        pixel_t win_q [9];

        always_ff @(posedge clk)
        begin
                if (wr_en)
                begin
                        mem[wr_addr] <= wr_data;
                end
        end

        // Gather the neighbourhood, row-major; anything off the tile is zero.
        always_comb
        begin
                int row;
                int col;
                int r;
                int c;
                row = int'(rd_centre) / TILE_W;
                col = int'(rd_centre) % TILE_W;
                for (int i = 0; i < 9; i++)
                begin
                        r = row + (i / 3) - 1;
                        c = col + (i % 3) - 1;
                        if (r < 0 || r >= TILE_W || c < 0 || c >= TILE_W)
                        begin
                                nbr[i] = '0;
                        end
                        else
                        begin
                                nbr[i] = mem[ADDR_W'(r * TILE_W + c)];
                        end
                end
        end

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        win_q <= '{default: '0};
                end
                else if (rd_en)
                begin
                        win_q <= nbr;
                end
        end

        assign win0 = win_q[0];
        assign win1 = win_q[1];
        assign win2 = win_q[2];
        assign win3 = win_q[3];
        assign win4 = win_q[4];
        assign win5 = win_q[5];
        assign win6 = win_q[6];
        assign win7 = win_q[7];
        assign win8 = win_q[8];

endmodule

// File: src/window_select.sv
`timescale 1ns/1ps

module window_select import tile_window_pkg::*;
(
        input  logic                  clk,
        input  logic                  rst_n,
        input  logic                  rd_req,
        input  logic [TILE_IDX_W-1:0] rd_tile,
        input  pixel_t                tile_win [TILE_COUNT][9],
        output pixel_t                pixelr1,
        output pixel_t                pixelr2,
        output pixel_t                pixelr3,
        output pixel_t                pixelr4,
        output pixel_t                pixelr5,
        output pixel_t                pixelr6,
        output pixel_t                pixelr7,
        output pixel_t                pixelr8,
        output pixel_t                pixelr9,
        output logic                  win_valid
);

        logic                  req_q;
        logic [TILE_IDX_W-1:0] tile_q;
        pixel_t                out_q [9];

        // The tile store answers one cycle after the request.
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        req_q     <= 1'b0;
                        tile_q    <= '0;
                        win_valid <= 1'b0;
                        out_q     <= '{default: '0};
                end
                else
                begin
                        req_q     <= rd_req;
                        tile_q    <= rd_tile;
                        win_valid <= req_q;
                        if (req_q)
                        begin
                                out_q <= tile_win[tile_q];
                        end
                end
        end

        assign pixelr1 = out_q[0];
        assign pixelr2 = out_q[1];
        assign pixelr3 = out_q[2];
        assign pixelr4 = out_q[3];
        assign pixelr5 = out_q[4];
        assign pixelr6 = out_q[5];
        assign pixelr7 = out_q[6];
        assign pixelr8 = out_q[7];
        assign pixelr9 = out_q[8];

endmodule

// File: src/tile_window_top.sv
`timescale 1ns/1ps

module tile_window_top import tile_window_pkg::*;
(
        input  logic   clk,
        input  logic   rst_n,
        input  logic   rd,
        input  pixel_t pixelw,
        output pixel_t pixelr1,
        output pixel_t pixelr2,
        output pixel_t pixelr3,
        output pixel_t pixelr4,
        output pixel_t pixelr5,
        output pixel_t pixelr6,
        output pixel_t pixelr7,
        output pixel_t pixelr8,
        output pixel_t pixelr9,
        output logic   win_valid,
        output logic   done
);

        logic [TILE_COUNT-1:0] wr_sel;
        logic [ADDR_W-1:0]     wr_addr;
        logic [TILE_COUNT-1:0] rd_sel;
        logic [ADDR_W-1:0]     rd_centre;
        logic [TILE_IDX_W-1:0] rd_tile;
        logic                  rd_req;
        pixel_t                tile_win [TILE_COUNT][9];

        tile_sequencer u_seq (
                .clk       (clk),
                .rst_n     (rst_n),
                .rd        (rd),
                .wr_sel    (wr_sel),
                .wr_addr   (wr_addr),
                .rd_sel    (rd_sel),
                .rd_centre (rd_centre),
                .rd_tile   (rd_tile),
                .rd_req    (rd_req),
                .done      (done)
        );

        // One store per tile, all sharing the pixel stream and addresses.
        for (genvar k = 0; k < TILE_COUNT; k++)
        begin : g_tile
                tile_store u_store (
                        .clk       (clk),
                        .rst_n     (rst_n),
                        .wr_en     (wr_sel[k]),
                        .wr_addr   (wr_addr),
                        .wr_data   (pixelw),
                        .rd_en     (rd_sel[k]),
                        .rd_centre (rd_centre),
                        .win0      (tile_win[k][0]),
                        .win1      (tile_win[k][1]),
                        .win2      (tile_win[k][2]),
                        .win3      (tile_win[k][3]),
                        .win4      (tile_win[k][4]),
                        .win5      (tile_win[k][5]),
                        .win6      (tile_win[k][6]),
                        .win7      (tile_win[k][7]),
                        .win8      (tile_win[k][8])
                );
        end

        window_select u_sel (
                .clk       (clk),
                .rst_n     (rst_n),
                .rd_req    (rd_req),
                .rd_tile   (rd_tile),
                .tile_win  (tile_win),
                .pixelr1   (pixelr1),
                .pixelr2   (pixelr2),
                .pixelr3   (pixelr3),
                .pixelr4   (pixelr4),
                .pixelr5   (pixelr5),
                .pixelr6   (pixelr6),
                .pixelr7   (pixelr7),
                .pixelr8   (pixelr8),
                .pixelr9   (pixelr9),
                .win_valid (win_valid)
        );

endmodule

// File: tests/tile_window_chk.sv
`timescale 1ns/1ps

module tile_window_chk import tile_window_pkg::*;
(
        input logic                  clk,
        input logic                  rst_n,
        input logic                  rd,
        input logic [TILE_COUNT-1:0] wr_sel,
        input logic [TILE_COUNT-1:0] rd_sel,
        input logic                  done,
        input seq_state_t            state
);

        sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                $onehot0(wr_sel) && $onehot0(rd_sel))
                else $error("A tile select has more than one bit set");

        done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
                done |=> done)
                else $error("done fell before reset");

        done_quiet: assert property (@(posedge clk) disable iff (!rst_n)
                (state == SEQ_DONE) |-> (wr_sel == '0 && rd_sel == '0))
                else $error("A tile select is active after the frame finished");

        // The first active cycle writes while the state is still idle.
        idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
                (state == SEQ_IDLE) |-> (rd_sel == '0 && (rd || wr_sel == '0)))
                else $error("A tile select is active in the idle state");

endmodule

bind tile_sequencer tile_window_chk u_chk (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd     (rd),
        .wr_sel (wr_sel),
        .rd_sel (rd_sel),
        .done   (done),
        .state  (state)
);

// File: tests/tile_window_tb.sv
`timescale 1ns/1ps

module tile_window_tb import tile_window_pkg::*;
();

        localparam int CASE_COUNT     = 97;
        localparam int RESET_CYCLES   = 4;
        localparam int TIMEOUT_CYCLES = CASE_COUNT + RESET_CYCLES + 20;

        typedef pixel_t [8:0] window_t;

        logic   clk;
        logic   rst_n;
        logic   rd;
        pixel_t pixelw;
        pixel_t pixelr1;
        pixel_t pixelr2;
        pixel_t pixelr3;
        pixel_t pixelr4;
        pixel_t pixelr5;
        pixel_t pixelr6;
        pixel_t pixelr7;
        pixel_t pixelr8;
        pixel_t pixelr9;
        logic   win_valid;
        logic   done;

        // Each entry is {rd, pixelw}.
        logic [8:0] cases [CASE_COUNT];

        pixel_t  model_mem [TILE_COUNT][TILE_PIXELS];
        int      frame_cnt;
        logic    model_done;
        logic    pend_valid;
        window_t pend_win;
        logic    exp_valid;
        window_t exp_win;

        int checks;
        int value_errors;
        int other_errors;
        int windows_seen;
        int cycles;

        tile_window_top DUT (
                .clk       (clk),
                .rst_n     (rst_n),
                .rd        (rd),
                .pixelw    (pixelw),
                .pixelr1   (pixelr1),
                .pixelr2   (pixelr2),
                .pixelr3   (pixelr3),
                .pixelr4   (pixelr4),
                .pixelr5   (pixelr5),
                .pixelr6   (pixelr6),
                .pixelr7   (pixelr7),
                .pixelr8   (pixelr8),
                .pixelr9   (pixelr9),
                .win_valid (win_valid),
                .done      (done)
        );

        initial
        begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // Zero-padded neighbourhood of one centre, row-major.
        function automatic window_t expect_window(input int tile, input int centre);
                window_t w;
                int      r;
                int      c;
                for (int i = 0; i < 9; i++)
                begin
                        r = centre / TILE_W + i / 3 - 1;
                        c = centre % TILE_W + i % 3 - 1;
                        if (r < 0 || r >= TILE_W || c < 0 || c >= TILE_W)
                                w[i] = '0;
                        else
                                w[i] = model_mem[tile][r * TILE_W + c];
                end
                return w;
        endfunction

        // Reference model, advanced once per rising edge.
        task automatic model_step();
                int slot;
                int phase;
                exp_valid = pend_valid;
                if (pend_valid)
                        exp_win = pend_win;
                pend_valid = 1'b0;
                if (rd && !model_done)
                begin
                        slot  = frame_cnt / SLOT_LEN;
                        phase = frame_cnt % SLOT_LEN;
                        if (phase >= WINDOW_LAG)
                        begin
                                pend_valid = 1'b1;
                                pend_win   = expect_window(slot, phase - WINDOW_LAG);
                        end
                        if (phase < TILE_PIXELS)
                                model_mem[slot][phase] = pixelw;
                        frame_cnt++;
                        if (frame_cnt == FRAME_LEN)
                                model_done = 1'b1;
                end
        endtask

        task automatic check_outputs(input string name);
                window_t got;
                got = {pixelr9, pixelr8, pixelr7, pixelr6, pixelr5,
                       pixelr4, pixelr3, pixelr2, pixelr1};
                checks++;
                assert (win_valid === exp_valid)
                else
                begin
                        $display("Error: %s win_valid expected %b actual %b", name, exp_valid,
                                 win_valid);
                        value_errors++;
                end
                assert (got === exp_win)
                else
                begin
                        $display("Error: %s window expected %h actual %h", name, exp_win, got);
                        value_errors++;
                end
                assert (done === model_done)
                else
                begin
                        $display("Error: %s done expected %b actual %b", name, model_done, done);
                        value_errors++;
                end
                if (win_valid === 1'b1)
                        windows_seen++;
        endtask

        // Inputs settle at the falling edge, outputs are checked at the next one.
        task automatic run_cycle(input string name);
                @(posedge clk);
                model_step();
                @(negedge clk);
                check_outputs(name);
        endtask

        initial
        begin
                rst_n        = 1'b0;
                rd           = 1'b0;
                pixelw       = '0;
                frame_cnt    = 0;
                model_done   = 1'b0;
                pend_valid   = 1'b0;
                pend_win     = '0;
                exp_valid    = 1'b0;
                exp_win      = '0;
                checks       = 0;
                value_errors = 0;
                other_errors = 0;
                windows_seen = 0;
                for (int t = 0; t < TILE_COUNT; t++)
                        for (int a = 0; a < TILE_PIXELS; a++)
                                model_mem[t][a] = '0;

                $readmemh("tests/tile_window_cases.txt", cases);
                assert (!$isunknown(cases[0]) && !$isunknown(cases[CASE_COUNT-1]))
                else
                begin
                        $display("The stimulus file could not be read completely");
                        other_errors++;
                end

                repeat (RESET_CYCLES)
                begin
                        @(negedge clk);
                        check_outputs("reset");
                end
                rst_n = 1'b1;

                for (int i = 0; i < CASE_COUNT; i++)
                begin
                        rd     = cases[i][8];
                        pixelw = cases[i][7:0];
                        run_cycle("window stream");
                end

                // Keep rd high so the frame can finish and later cycles stay inert.
                rd     = 1'b1;
                pixelw = 8'h5a;
                while (done !== 1'b1)
                        run_cycle("frame end");
                repeat (3)
                        run_cycle("after done");

                assert (windows_seen == TILE_COUNT * TILE_PIXELS)
                else
                begin
                        $display("Error: window count expected %0d actual %0d",
                                 TILE_COUNT * TILE_PIXELS, windows_seen);
                        value_errors++;
                end

                $display("Checks: %0d, value errors: %0d, other errors: %0d, windows: %0d",
                         checks, value_errors, other_errors, windows_seen);
                if (value_errors == 0 && other_errors == 0)
                        $display("TEST PASSED");
                else
                        $display("TEST FAILED");
                $finish;
        end

        initial
        begin
                cycles = 0;
                while (cycles < TIMEOUT_CYCLES)
                begin
                        @(posedge clk);
                        cycles++;
                end
                $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("TEST FAILED");
                $finish;
        end

endmodule

// File: tests/tile_window_cases.txt
// One stimulus cycle per line: a 9-bit hex word, bit 8 is rd, bits 7:0 are pixelw.
// Four slots of 22 active cycles with a few rd-low pauses, then cycles after done.
110
111
112
113
114
115
0ee
0d1
116
117
118
119
11a
11b
11c
11d
11e
11f
1c0
1c1
1c2
0ee
1c3
1c4
1c5
120
121
122
123
124
125
126
127
128
129
12a
12b
12c
12d
12e
12f
1c0
1c1
1c2
1c3
1c4
1c5
130
131
132
133
134
135
136
137
0e7
138
139
13a
13b
13c
13d
13e
13f
1c0
1c1
1c2
1c3
1c4
1c5
140
141
142
143
144
145
146
147
148
149
14a
14b
14c
14d
14e
14f
1c0
1c1
1c2
1c3
1c4
1c5
177
178
079
17a
17b

// File: project.f
src/tile_window_pkg.sv
src/tile_sequencer.sv
src/tile_store.sv
src/window_select.sv
src/tile_window_top.sv
tests/tile_window_chk.sv
tests/tile_window_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the tile window testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tile_window_tb \
        -f project.f -o tile_window_sim > build.log 2>&1
if [ $? -ne 0 ]; then
        cat build.log
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/tile_window_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -q "TEST FAILED" sim.log; then
        exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
        echo "Simulation ended without a result"
        exit 1
fi
exit 0
